// ==== logic/cce_msg_pkg.sv ====
`default_nettype none

package cce_msg_pkg;

  localparam int unsigned addr_width   = 16;
  localparam int unsigned lce_id_width = 2;
  localparam int unsigned wb_adr_width = 7;
  localparam int unsigned wb_dat_width = 24;

  typedef logic [addr_width-1:0]   addr_t;
  typedef logic [lce_id_width-1:0] lce_id_t;

  typedef enum logic [0:0] {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_cmd_set_shared = 2'd0,
    e_cmd_set_excl   = 2'd1,
    e_cmd_invalidate = 2'd2,
    e_cmd_writeback  = 2'd3
  } lce_cmd_type_e;

  typedef struct packed {
    lce_id_t       lce_id;
    lce_req_type_e req_type;
    addr_t         addr;
  } lce_req_t;

  typedef struct packed {
    lce_id_t       dst_id;
    lce_cmd_type_e cmd_type;
    addr_t         addr;
  } lce_cmd_t;

  // Classic Wishbone for the configuration port only
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [wb_adr_width-1:0] adr;
    logic [wb_dat_width-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [wb_dat_width-1:0] dat;
    logic                    ack;
  } wb_rsp_t;

  // Run-enable control register sits just above the microcode words
  localparam logic [wb_adr_width-1:0] ctrl_addr = 7'd64;

endpackage

`default_nettype wire

// ==== logic/cce_inst_pkg.sv ====
`default_nettype none

package cce_inst_pkg;

  localparam int unsigned inst_width = 24;
  localparam int unsigned pc_width   = 6;
  localparam int unsigned num_gpr    = 4;
  localparam int unsigned imm_width  = 14;

  typedef logic [pc_width-1:0]                pc_t;
  typedef logic [$clog2(num_gpr)-1:0]         gpr_sel_t;
  typedef logic [cce_msg_pkg::addr_width-1:0] gpr_t;
  typedef logic [imm_width-1:0]               imm_t;

  typedef enum logic [3:0] {
    e_op_addi  = 4'd0,
    e_op_and   = 4'd1,
    e_op_jmp   = 4'd2,
    e_op_bwr   = 4'd3,
    e_op_poph  = 4'd4,
    e_op_pushc = 4'd5
  } opcode_e;

  // Microcode word as stored
  typedef struct packed {
    opcode_e  opcode;
    gpr_sel_t dst;
    gpr_sel_t src_a;
    gpr_sel_t src_b;
    imm_t     imm;
  } inst_t;

  typedef struct packed {
    logic     v;
    opcode_e  opcode;
    gpr_sel_t dst;
    gpr_sel_t src_a;
    gpr_sel_t src_b;
    imm_t     imm;
    pc_t      pc;
  } decoded_t;

  // Execute output for the register file and message unit
  typedef struct packed {
    logic                       v;
    opcode_e                    opcode;
    gpr_sel_t                   dst;
    gpr_t                       value;
    cce_msg_pkg::lce_cmd_type_e cmd_type;
    logic                       taken;
  } ex_result_t;

endpackage

`default_nettype wire

// ==== logic/cce_ucode_ram.sv ====
`default_nettype none

module cce_ucode_ram (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  cce_msg_pkg::wb_req_t wb_req_i,
  output cce_msg_pkg::wb_rsp_t wb_rsp_o,
  input  logic                 stall_i,
  input  logic                 flush_i,
  input  cce_inst_pkg::pc_t    redirect_pc_i,
  output cce_inst_pkg::inst_t  inst_o,
  output cce_inst_pkg::pc_t    inst_pc_o,
  output logic                 inst_v_o
);
  import cce_msg_pkg::*;
  import cce_inst_pkg::*;

  logic [inst_width-1:0]   ucode_mem [2**pc_width];
  logic                    run_en_q;
  logic                    ack_q;
  logic [wb_dat_width-1:0] rd_dat_q;
  pc_t                     fetch_pc_q;
  inst_t                   inst_q;
  pc_t                     inst_pc_q;
  logic                    inst_v_q;
  logic                    wb_access;
  logic                    wb_is_ctrl;
  pc_t                     wb_word;

  // New access only while no ack is out
  assign wb_access  = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign wb_is_ctrl = (wb_req_i.adr == ctrl_addr);
  assign wb_word    = wb_req_i.adr[pc_width-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q    <= 1'b0;
      run_en_q <= 1'b0;
    end else begin
      ack_q <= wb_access;
      if (wb_access && wb_req_i.we && wb_is_ctrl) begin
        run_en_q <= wb_req_i.dat[0];
      end
    end
  end

  // Store write and read-back
  always_ff @(posedge clk_i) begin
    if (wb_access) begin
      if (wb_req_i.we && (wb_req_i.adr < ctrl_addr)) begin
        ucode_mem[wb_word] <= wb_req_i.dat;
      end
      rd_dat_q <= wb_is_ctrl ? {{(wb_dat_width-1){1'b0}}, run_en_q} : ucode_mem[wb_word];
    end
  end

  // Fetch PC with static not-taken prediction
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_pc_q <= '0;
      inst_v_q   <= 1'b0;
    end else if (!run_en_q) begin
      fetch_pc_q <= '0;
      inst_v_q   <= 1'b0;
    end else if (flush_i) begin
      fetch_pc_q <= redirect_pc_i;
      inst_v_q   <= 1'b0;
    end else if (!stall_i) begin
      fetch_pc_q <= fetch_pc_q + pc_t'(1);
      inst_v_q   <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_q    <= inst_t'(ucode_mem[fetch_pc_q]);
      inst_pc_q <= fetch_pc_q;
    end
  end

  assign wb_rsp_o.dat = rd_dat_q;
  assign wb_rsp_o.ack = ack_q;
  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;
  assign inst_v_o     = inst_v_q;

  a_ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_q |=> !ack_q);

  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_q |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

// ==== logic/cce_inst_decode.sv ====
`default_nettype none

module cce_inst_decode (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  cce_inst_pkg::inst_t    inst_i,
  input  cce_inst_pkg::pc_t      inst_pc_i,
  input  logic                   inst_v_i,
  input  logic                   stall_i,
  input  logic                   flush_i,
  output cce_inst_pkg::decoded_t decoded_o
);
  import cce_inst_pkg::*;

  logic  v_q;
  inst_t inst_q;
  pc_t   pc_q;

  // Valid bit is killed by a taken branch in execute
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_q <= 1'b0;
    end else if (flush_i) begin
      v_q <= 1'b0;
    end else if (!stall_i) begin
      v_q <= inst_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_q <= inst_i;
      pc_q   <= inst_pc_i;
    end
  end

  // Field split of the held word
  always_comb begin
    decoded_o.v      = v_q;
    decoded_o.opcode = inst_q.opcode;
    decoded_o.dst    = inst_q.dst;
    decoded_o.src_a  = inst_q.src_a;
    decoded_o.src_b  = inst_q.src_b;
    decoded_o.imm    = inst_q.imm;
    decoded_o.pc     = pc_q;
  end

  a_legal_opcode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    decoded_o.v |-> decoded_o.opcode inside {e_op_addi, e_op_and, e_op_jmp,
                                             e_op_bwr, e_op_poph, e_op_pushc});

endmodule

`default_nettype wire

// ==== logic/cce_execute.sv ====
`default_nettype none

module cce_execute (
  input  cce_inst_pkg::decoded_t                      decoded_i,
  input  cce_inst_pkg::gpr_t [cce_inst_pkg::num_gpr-1:0] gpr_i,
  input  cce_msg_pkg::lce_req_type_e                  mshr_req_type_i,
  input  logic                                        stall_i,
  output cce_inst_pkg::ex_result_t                    result_o,
  output logic                                        flush_o,
  output cce_inst_pkg::pc_t                           redirect_pc_o
);
  import cce_msg_pkg::*;
  import cce_inst_pkg::*;

  gpr_t src_a_val;
  gpr_t src_b_val;
  gpr_t alu_res;
  logic taken;

  assign src_a_val = gpr_i[decoded_i.src_a];
  assign src_b_val = gpr_i[decoded_i.src_b];

  // ALU and branch resolution
  // pushc and poph fall through with src_a as the value
  always_comb begin
    alu_res = src_a_val;
    taken   = 1'b0;
    case (decoded_i.opcode)
      e_op_addi: begin
        alu_res = src_a_val + gpr_t'(decoded_i.imm);
      end
      e_op_and: begin
        alu_res = src_a_val & src_b_val;
      end
      e_op_jmp: begin
        taken = 1'b1;
      end
      e_op_bwr: begin
        taken = (mshr_req_type_i == e_req_wr);
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  end

  always_comb begin
    result_o.v        = decoded_i.v;
    result_o.opcode   = decoded_i.opcode;
    result_o.dst      = decoded_i.dst;
    result_o.value    = alu_res;
    result_o.cmd_type = lce_cmd_type_e'(decoded_i.imm[1:0]);
    result_o.taken    = decoded_i.v && taken;
  end

  // Any taken branch redirects under static not-taken prediction
  assign flush_o       = decoded_i.v && taken && !stall_i;
  assign redirect_pc_o = decoded_i.imm[pc_width-1:0];

endmodule

`default_nettype wire

// ==== logic/cce_result.sv ====
`default_nettype none

module cce_result (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  cce_inst_pkg::ex_result_t                       result_i,
  input  cce_msg_pkg::lce_req_t                          lce_req_i,
  input  logic                                           lce_req_v_i,
  output logic                                           lce_req_yumi_o,
  output cce_msg_pkg::lce_cmd_t                          lce_cmd_o,
  output logic                                           lce_cmd_v_o,
  input  logic                                           lce_cmd_ready_i,
  output cce_inst_pkg::gpr_t [cce_inst_pkg::num_gpr-1:0] gpr_o,
  output cce_msg_pkg::lce_req_type_e                     mshr_req_type_o,
  output logic                                           stall_o
);
  import cce_msg_pkg::*;
  import cce_inst_pkg::*;

  gpr_t [num_gpr-1:0] gpr_q;
  lce_id_t            mshr_lce_q;
  lce_req_type_e      mshr_type_q;
  lce_cmd_t           cmd_q;
  logic               cmd_v_q;
  logic               is_alu;
  logic               is_poph;
  logic               is_pushc;
  logic               cmd_held;
  logic               cmd_load;

  assign is_alu   = result_i.v && (result_i.opcode inside {e_op_addi, e_op_and});
  assign is_poph  = result_i.v && (result_i.opcode == e_op_poph);
  assign is_pushc = result_i.v && (result_i.opcode == e_op_pushc);

  // Previous command still waiting on the LCE
  assign cmd_held = cmd_v_q && !lce_cmd_ready_i;
  assign cmd_load = is_pushc && !cmd_held;

  assign stall_o        = (is_poph && !lce_req_v_i) || (is_pushc && cmd_held);
  assign lce_req_yumi_o = is_poph && lce_req_v_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpr_q       <= '0;
      mshr_lce_q  <= '0;
      mshr_type_q <= e_req_rd;
      cmd_v_q     <= 1'b0;
    end else begin
      if (is_alu) begin
        gpr_q[result_i.dst] <= result_i.value;
      end
      // Popped request fills the MSHR and the destination GPR
      if (lce_req_yumi_o) begin
        gpr_q[result_i.dst] <= lce_req_i.addr;
        mshr_lce_q          <= lce_req_i.lce_id;
        mshr_type_q         <= lce_req_i.req_type;
      end
      if (cmd_load) begin
        cmd_v_q <= 1'b1;
      end else if (lce_cmd_ready_i) begin
        cmd_v_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_load) begin
      cmd_q.dst_id   <= mshr_lce_q;
      cmd_q.cmd_type <= result_i.cmd_type;
      cmd_q.addr     <= result_i.value;
    end
  end

  assign gpr_o           = gpr_q;
  assign mshr_req_type_o = mshr_type_q;
  assign lce_cmd_o       = cmd_q;
  assign lce_cmd_v_o     = cmd_v_q;

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_o));

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lce_req_yumi_o |-> lce_req_v_i);

endmodule

`default_nettype wire

// ==== logic/cce_top.sv ====
`default_nettype none

module cce_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  cce_msg_pkg::wb_req_t  wb_req_i,
  output cce_msg_pkg::wb_rsp_t  wb_rsp_o,
  input  cce_msg_pkg::lce_req_t lce_req_i,
  input  logic                  lce_req_v_i,
  output logic                  lce_req_yumi_o,
  output cce_msg_pkg::lce_cmd_t lce_cmd_o,
  output logic                  lce_cmd_v_o,
  input  logic                  lce_cmd_ready_i
);
  import cce_msg_pkg::*;
  import cce_inst_pkg::*;

  // Fetch to decode
  inst_t              fetch_inst;
  pc_t                fetch_pc;
  logic               fetch_v;
  decoded_t           decoded;
  ex_result_t         ex_result;
  // Branch redirect back to fetch
  logic               flush;
  pc_t                redirect_pc;
  gpr_t [num_gpr-1:0] gpr;
  lce_req_type_e      mshr_req_type;
  logic               stall;

  cce_ucode_ram ucode_ram (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .stall_i      (stall),
    .flush_i      (flush),
    .redirect_pc_i(redirect_pc),
    .inst_o       (fetch_inst),
    .inst_pc_o    (fetch_pc),
    .inst_v_o     (fetch_v)
  );

  cce_inst_decode inst_decode (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .inst_i   (fetch_inst),
    .inst_pc_i(fetch_pc),
    .inst_v_i (fetch_v),
    .stall_i  (stall),
    .flush_i  (flush),
    .decoded_o(decoded)
  );

  cce_execute execute (
    .decoded_i      (decoded),
    .gpr_i          (gpr),
    .mshr_req_type_i(mshr_req_type),
    .stall_i        (stall),
    .result_o       (ex_result),
    .flush_o        (flush),
    .redirect_pc_o  (redirect_pc)
  );

  cce_result result (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .result_i       (ex_result),
    .lce_req_i      (lce_req_i),
    .lce_req_v_i    (lce_req_v_i),
    .lce_req_yumi_o (lce_req_yumi_o),
    .lce_cmd_o      (lce_cmd_o),
    .lce_cmd_v_o    (lce_cmd_v_o),
    .lce_cmd_ready_i(lce_cmd_ready_i),
    .gpr_o          (gpr),
    .mshr_req_type_o(mshr_req_type),
    .stall_o        (stall)
  );

endmodule

`default_nettype wire

// ==== verif/cce_tb.sv ====
`default_nettype none

module cce_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import cce_msg_pkg::*;
  import cce_inst_pkg::*;

  localparam int unsigned num_reqs      = 24;
  localparam int unsigned wb_timeout    = 20;
  localparam int unsigned drain_timeout = 4000;
  localparam addr_t       line_mask     = 16'hFFC0;

  logic        clk          = 1'b0;
  logic        arst_n       = 1'b0;
  int          seed         = 85633;
  logic        run_enabled  = 1'b0;
  logic        req_offer_en = 1'b0;
  logic        req_popped   = 1'b0;
  int unsigned req_sent     = 0;
  int unsigned pop_count    = 0;
  int unsigned cmd_count    = 0;
  int unsigned ack_count    = 0;
  int unsigned wb_count     = 0;

  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  lce_req_t lce_req;
  logic     lce_req_v;
  logic     lce_req_yumi;
  lce_cmd_t lce_cmd;
  logic     lce_cmd_v;
  logic     lce_cmd_ready;

  inst_t    prog [11];
  lce_req_t pop_q [$];
  lce_req_t exp_req;
  lce_cmd_t exp_cmd;
  logic [31:0] rnd;

  cce_top cce_top_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .wb_req_i       (wb_req),
    .wb_rsp_o       (wb_rsp),
    .lce_req_i      (lce_req),
    .lce_req_v_i    (lce_req_v),
    .lce_req_yumi_o (lce_req_yumi),
    .lce_cmd_o      (lce_cmd),
    .lce_cmd_v_o    (lce_cmd_v),
    .lce_cmd_ready_i(lce_cmd_ready)
  );

  always #2 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic inst_t make_inst(input opcode_e op, input gpr_sel_t dst,
                                      input gpr_sel_t src_a, input gpr_sel_t src_b,
                                      input imm_t imm);
    inst_t inst;
    inst.opcode = op;
    inst.dst    = dst;
    inst.src_a  = src_a;
    inst.src_b  = src_b;
    inst.imm    = imm;
    return inst;
  endfunction

  // Four adds of 0x3FF0 build the line mask 0xFFC0 in r2
  task automatic build_program();
    for (int i = 0; i < 4; i++) begin
      prog[i] = make_inst(e_op_addi, 2'd2, 2'd2, 2'd0, 14'h3FF0);
    end
    prog[4]  = make_inst(e_op_poph, 2'd0, 2'd0, 2'd0, 14'd0);
    prog[5]  = make_inst(e_op_and, 2'd1, 2'd0, 2'd2, 14'd0);
    prog[6]  = make_inst(e_op_bwr, 2'd0, 2'd0, 2'd0, 14'd9);
    prog[7]  = make_inst(e_op_pushc, 2'd0, 2'd1, 2'd0, 14'(e_cmd_set_shared));
    prog[8]  = make_inst(e_op_jmp, 2'd0, 2'd0, 2'd0, 14'd4);
    // Write path
    prog[9]  = make_inst(e_op_pushc, 2'd0, 2'd1, 2'd0, 14'(e_cmd_set_excl));
    prog[10] = make_inst(e_op_jmp, 2'd0, 2'd0, 2'd0, 14'd4);
  endtask

  // One classic cycle that starts and ends on a falling edge
  task automatic wb_transfer(input logic we, input logic [6:0] adr,
                             input logic [23:0] dat, output logic [23:0] rdat);
    int unsigned cycles;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    cycles = 0;
    @(negedge clk);
    while (!wb_rsp.ack && cycles < wb_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!wb_rsp.ack) begin
      report_error($sformatf("Wishbone ack never came for address 0x%h", adr));
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
    wb_count++;
    @(negedge clk);
    a_single_ack: assert (!wb_rsp.ack)
      else report_error($sformatf("Wishbone ack held longer than one cycle at 0x%h", adr));
  endtask

  // LCE requester and command sink driven on the falling edge
  always @(negedge clk) begin
    rnd = $random(seed);
    lce_cmd_ready = (rnd[1:0] != 2'b00);
    if (req_offer_en && (!lce_req_v || req_popped)) begin
      if (req_sent < num_reqs && rnd[4:2] != 3'b000) begin
        lce_req.lce_id   = lce_id_t'(rnd[7:6]);
        lce_req.req_type = lce_req_type_e'(rnd[5]);
        lce_req.addr     = addr_t'($random(seed));
        lce_req_v        = 1'b1;
        req_sent++;
      end else begin
        lce_req_v = 1'b0;
      end
    end
    req_popped = 1'b0;
  end

  // Scoreboard on the rising edge
  always @(posedge clk) begin
    if (arst_n) begin
      if (wb_rsp.ack) begin
        ack_count++;
      end
      if (lce_cmd_v && lce_cmd_ready) begin
        a_cmd_has_req: assert (pop_q.size() > 0)
          else report_error("Command accepted with no popped request outstanding");
        exp_req          = pop_q.pop_front();
        exp_cmd.dst_id   = exp_req.lce_id;
        exp_cmd.cmd_type = (exp_req.req_type == e_req_wr) ? e_cmd_set_excl : e_cmd_set_shared;
        exp_cmd.addr     = exp_req.addr & line_mask;
        a_cmd_dst: assert (lce_cmd.dst_id == exp_cmd.dst_id)
          else report_error($sformatf("Mismatch lce_cmd_o.dst_id: expected 0x%h, got 0x%h",
                                      exp_cmd.dst_id, lce_cmd.dst_id));
        a_cmd_type: assert (lce_cmd.cmd_type == exp_cmd.cmd_type)
          else report_error($sformatf("Mismatch lce_cmd_o.cmd_type: expected 0x%h, got 0x%h",
                                      exp_cmd.cmd_type, lce_cmd.cmd_type));
        a_cmd_addr: assert (lce_cmd.addr == exp_cmd.addr)
          else report_error($sformatf("Mismatch lce_cmd_o.addr: expected 0x%h, got 0x%h",
                                      exp_cmd.addr, lce_cmd.addr));
        cmd_count++;
      end
      if (lce_req_yumi) begin
        pop_q.push_back(lce_req);
        pop_count++;
        req_popped = 1'b1;
      end
    end
  end

  a_no_pop_before_run: assert property (@(posedge clk) disable iff (!arst_n)
    !run_enabled |-> !lce_req_yumi)
    else report_error("Request popped before run-enable was set");

  a_yumi_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
    lce_req_yumi |-> lce_req_v)
    else report_error("lce_req_yumi_o high without a valid request");

  a_cmd_v_held: assert property (@(posedge clk) disable iff (!arst_n)
    lce_cmd_v && !lce_cmd_ready |=> lce_cmd_v)
    else report_error("lce_cmd_o valid dropped before the command was accepted");

  a_cmd_data_held: assert property (@(posedge clk) disable iff (!arst_n)
    lce_cmd_v && !lce_cmd_ready |=> $stable(lce_cmd))
    else report_error($sformatf("Mismatch lce_cmd_o: changed to 0x%h while held", lce_cmd));

  initial begin : main
    logic [23:0] rdat;
    int unsigned cycles;
    wb_req        = '0;
    lce_req       = '0;
    lce_req_v     = 1'b0;
    lce_cmd_ready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    a_reset_state: assert (!lce_cmd_v && !lce_req_yumi && !wb_rsp.ack)
      else report_error("Outputs not low after reset");

    // A request waits on the port while the program loads
    req_offer_en = 1'b1;
    build_program();
    foreach (prog[i]) begin
      wb_transfer(1'b1, 7'(i), prog[i], rdat);
    end
    foreach (prog[i]) begin
      wb_transfer(1'b0, 7'(i), '0, rdat);
      a_readback: assert (rdat == prog[i])
        else report_error($sformatf("Mismatch wb_rsp_o.dat at 0x%h: expected 0x%h, got 0x%h",
                                    i, prog[i], rdat));
    end
    wb_transfer(1'b1, ctrl_addr, 24'd1, rdat);
    run_enabled = 1'b1;
    wb_transfer(1'b0, ctrl_addr, '0, rdat);
    a_ctrl_readback: assert (rdat == 24'd1)
      else report_error($sformatf("Mismatch wb_rsp_o.dat at ctrl: expected 0x1, got 0x%h", rdat));

    cycles = 0;
    while (cmd_count < num_reqs && cycles < drain_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (cmd_count < num_reqs) begin
      report_error("Timed out waiting for all commands to drain");
    end
    a_counts_match: assert (pop_count == cmd_count && pop_q.size() == 0)
      else report_error($sformatf("Mismatch command count: popped 0x%h, accepted 0x%h",
                                  pop_count, cmd_count));
    a_ack_count: assert (ack_count == wb_count)
      else report_error($sformatf("Mismatch wb_rsp_o.ack count: expected 0x%h, got 0x%h",
                                  wb_count, ack_count));
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/cce_msg_pkg.sv
logic/cce_inst_pkg.sv
logic/cce_ucode_ram.sv
logic/cce_inst_decode.sv
logic/cce_execute.sv
logic/cce_result.sv
logic/cce_top.sv
verif/cce_tb.sv

// ==== Bender.yml ====
package:
  name: cce

sources:
  - logic/cce_msg_pkg.sv
  - logic/cce_inst_pkg.sv
  - logic/cce_ucode_ram.sv
  - logic/cce_inst_decode.sv
  - logic/cce_execute.sv
  - logic/cce_result.sv
  - logic/cce_top.sv
  - target: test
    files:
      - verif/cce_tb.sv
